// File: Bender.yml
package:
  name: pathCipher

sources:
  - source/pathCipherPkg.sv
  - source/burstIngress.sv
  - source/keystreamLane.sv
  - source/burstEgress.sv
  - source/pathCipher.sv
  - target: test
    files:
      - tb/pathCipherTb.sv

// File: pathCipher.f
source/pathCipherPkg.sv
source/burstIngress.sv
source/keystreamLane.sv
source/burstEgress.sv
source/pathCipher.sv
tb/pathCipherTb.sv

// File: source/burstEgress.sv
// Burst egress: tag delay line matching the lanes, lane merge, IV restore
// Output register, routing to memory or backend, advance generation

`timescale 1ns/100ps

module burstEgress import pathCipherPkg::*; #(
    parameter int LaneStages = 4
) (
    input  logic                  Clock,
    input  logic                  rstN,
    input  burstTagT              tag,
    input  laneOutT               laneOut [LaneCount],
    output logic                  advance,
    output logic [BurstWidth-1:0] memOut,
    output logic [MaskWidth-1:0]  memOutMask,
    output logic                  memOutValid,
    input  logic                  memOutReady,
    output logic [BurstWidth-1:0] backendRData,
    output logic                  backendRValid,
    input  logic                  backendRReady
);

    localparam int Last = LaneStages - 1;

    burstTagT              tagQ [LaneStages];
    logic [BurstWidth-1:0] merged;
    logic [LaneCount-1:0]  laneValid;
    logic                  destReady;

    logic                  outValid;
    logic [BurstWidth-1:0] outData;
    logic [MaskWidth-1:0]  outMask;
    pathDirT               outDir;

    // ------------------------------
    // Tag delay line
    // ------------------------------

    // Same depth and enable as the lane pipelines
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int s = 0; s < LaneStages; s++) begin
                tagQ[s].valid <= 1'b0;
            end
        end else if (advance) begin
            tagQ[0] <= tag;
            for (int s = 1; s < LaneStages; s++) begin
                tagQ[s] <= tagQ[s-1];
            end
        end
    end

    // ------------------------------
    // Lane merge
    // ------------------------------

    always_comb begin
        for (int j = 0; j < LaneCount; j++) begin
            merged[j*LaneWidth +: LaneWidth] = laneOut[j].data;
            laneValid[j] = laneOut[j].valid;
        end
        // Header keeps its cleartext IV
        if (tagQ[Last].header) begin
            merged[IvWidth-1:0] = tagQ[Last].iv;
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------

    assign destReady = (outDir == PathWrite) ? memOutReady : backendRReady;

    // Whole datapath stalls while a result waits
    assign advance = !(outValid && !destReady);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (advance) begin
            outValid <= tagQ[Last].valid;
        end
    end

    always_ff @(posedge Clock) begin
        if (advance) begin
            outData <= merged;
            outMask <= tagQ[Last].mask;
            outDir  <= tagQ[Last].dir;
        end
    end

    assign memOutValid   = outValid && (outDir == PathWrite);
    assign backendRValid = outValid && (outDir == PathRead);
    assign memOut        = outData;
    assign memOutMask    = outMask;
    assign backendRData  = outData;

    // ------------------------------
    // Checks
    // ------------------------------

    assert property (@(posedge Clock) disable iff (!rstN)
        memOutValid && !memOutReady |=>
            memOutValid && $stable(memOut) && $stable(memOutMask));

    assert property (@(posedge Clock) disable iff (!rstN)
        backendRValid && !backendRReady |=>
            backendRValid && $stable(backendRData));

    // Lanes and tag line must stay in lockstep
    assert property (@(posedge Clock) disable iff (!rstN)
        laneValid == {LaneCount{tagQ[Last].valid}});

endmodule

// File: source/burstIngress.sv
// Burst ingress: path direction, input select, bucket and path position
// IV capture and counter block issue to the keystream lanes

`timescale 1ns/100ps

module burstIngress import pathCipherPkg::*; #(
    parameter int BucketBursts = 4,
    parameter int PathBursts   = 12
) (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic [BurstWidth-1:0] memIn,
    input  logic                  memInValid,
    output logic                  memInReady,
    input  logic [BurstWidth-1:0] backendWData,
    input  logic [MaskWidth-1:0]  backendWMask,
    input  logic                  backendWValid,
    output logic                  backendWReady,
    input  logic                  advance,
    output laneInT                laneIn [LaneCount],
    output burstTagT              tag
);

    localparam int BucketPosWidth = (BucketBursts > 1) ? $clog2(BucketBursts) : 1;
    localparam int PathPosWidth   = (PathBursts > 1) ? $clog2(PathBursts) : 1;

    pathDirT                   direction;
    logic                      armed;
    logic [BucketPosWidth-1:0] bucketPos;
    logic [PathPosWidth-1:0]   pathPos;
    logic [IvWidth-1:0]        ivReg;
    logic [IvWidth-1:0]        ivCur;
    logic [BurstWidth-1:0]     burst;
    logic                      accept;
    logic                      isHeader;
    logic                      bucketEnd;
    logic                      pathEnd;

    // ------------------------------
    // Input select
    // ------------------------------

    // Held low for one cycle out of reset
    assign memInReady    = armed & advance & (direction == PathRead);
    assign backendWReady = armed & advance & (direction == PathWrite);

    assign accept = (direction == PathRead) ? (memInValid & memInReady)
                                            : (backendWValid & backendWReady);
    assign burst  = (direction == PathRead) ? memIn : backendWData;

    assign isHeader  = (bucketPos == '0);
    assign bucketEnd = (bucketPos == BucketPosWidth'(BucketBursts - 1));
    assign pathEnd   = (pathPos == PathPosWidth'(PathBursts - 1));

    // Header bursts use their own IV straight away
    assign ivCur = isHeader ? burst[IvWidth-1:0] : ivReg;

    // ------------------------------
    // Position and direction
    // ------------------------------

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            armed     <= 1'b0;
            direction <= PathRead;
            bucketPos <= '0;
            pathPos   <= '0;
        end else begin
            armed <= 1'b1;
            if (accept) begin
                bucketPos <= bucketEnd ? '0 : bucketPos + 1'b1;
                pathPos   <= pathEnd ? '0 : pathPos + 1'b1;
                if (pathEnd) begin
                    direction <= (direction == PathRead) ? PathWrite : PathRead;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (accept && isHeader) begin
            ivReg <= burst[IvWidth-1:0];
        end
    end

    // ------------------------------
    // Lane issue
    // ------------------------------

    // Counter is IV plus burst offset in the bucket plus lane index
    always_comb begin
        for (int j = 0; j < LaneCount; j++) begin
            laneIn[j].valid   = accept;
            laneIn[j].counter = LaneWidth'(ivCur)
                              + LaneWidth'(bucketPos) * LaneWidth'(LaneCount)
                              + LaneWidth'(j);
            laneIn[j].data    = burst[j*LaneWidth +: LaneWidth];
        end
    end

    assign tag.valid  = accept;
    assign tag.header = isHeader;
    assign tag.iv     = ivCur;
    assign tag.mask   = (direction == PathWrite) ? backendWMask : '0;
    assign tag.dir    = direction;

    // Only one source may be offered ready at a time
    assert property (@(posedge Clock) disable iff (!rstN)
        !(memInReady && backendWReady));

endmodule

// File: source/keystreamLane.sv
// One keystream lane: pipelined add-rotate-xor rounds on the counter block
// Data slice XORed with the final state at the last stage

`timescale 1ns/100ps

module keystreamLane import pathCipherPkg::*; #(
    parameter int                   LaneStages = 4,
    parameter logic [LaneWidth-1:0] Key        = '0
) (
    input  logic    Clock,
    input  logic    rstN,
    input  logic    advance,
    input  laneInT  laneIn,
    output laneOutT laneOut
);

    localparam int Last = LaneStages - 1;

    logic                 validQ [LaneStages];
    logic [LaneWidth-1:0] dataQ  [LaneStages];
    logic [LaneWidth-1:0] stateQ [LaneStages];

    // Round r: xor key, rotate left 13, add r
    function automatic logic [LaneWidth-1:0] mixRound(
        input logic [LaneWidth-1:0] state,
        input int                   round
    );
        logic [LaneWidth-1:0] keyed;
        keyed = state ^ Key;
        return {keyed[LaneWidth-14:0], keyed[LaneWidth-1:LaneWidth-13]}
             + LaneWidth'(round);
    endfunction

    // ------------------------------
    // Valid pipeline
    // ------------------------------

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int s = 0; s < LaneStages; s++) begin
                validQ[s] <= 1'b0;
            end
        end else if (advance) begin
            validQ[0] <= laneIn.valid;
            for (int s = 1; s < LaneStages; s++) begin
                validQ[s] <= validQ[s-1];
            end
        end
    end

    // ------------------------------
    // Data and state pipeline
    // ------------------------------

    // Stage s applies round s+1
    always_ff @(posedge Clock) begin
        if (advance) begin
            dataQ[0]  <= laneIn.data;
            stateQ[0] <= mixRound(laneIn.counter, 1);
            for (int s = 1; s < LaneStages; s++) begin
                dataQ[s]  <= dataQ[s-1];
                stateQ[s] <= mixRound(stateQ[s-1], s + 1);
            end
        end
    end

    assign laneOut.valid = validQ[Last];
    assign laneOut.data  = dataQ[Last] ^ stateQ[Last];

    assert property (@(posedge Clock) disable iff (!rstN)
        !$isunknown(laneOut.valid));

endmodule

// File: source/pathCipher.sv
// Path cipher top level
// Ingress, generated keystream lanes and egress

`timescale 1ns/100ps

module pathCipher import pathCipherPkg::*; #(
    parameter int                   LaneStages   = 4,
    parameter int                   BucketBursts = 4,
    parameter int                   PathBursts   = 12,
    parameter logic [LaneWidth-1:0] Key          = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0
) (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic [BurstWidth-1:0] memIn,
    input  logic                  memInValid,
    output logic                  memInReady,
    output logic [BurstWidth-1:0] memOut,
    output logic [MaskWidth-1:0]  memOutMask,
    output logic                  memOutValid,
    input  logic                  memOutReady,
    input  logic [BurstWidth-1:0] backendWData,
    input  logic [MaskWidth-1:0]  backendWMask,
    input  logic                  backendWValid,
    output logic                  backendWReady,
    output logic [BurstWidth-1:0] backendRData,
    output logic                  backendRValid,
    input  logic                  backendRReady
);

    laneInT   laneIn  [LaneCount];
    laneOutT  laneOut [LaneCount];
    burstTagT tag;
    logic     advance;

    burstIngress #(
        .BucketBursts(BucketBursts),
        .PathBursts(PathBursts)
    ) ingress (
        .Clock(Clock),
        .rstN(rstN),
        .memIn(memIn),
        .memInValid(memInValid),
        .memInReady(memInReady),
        .backendWData(backendWData),
        .backendWMask(backendWMask),
        .backendWValid(backendWValid),
        .backendWReady(backendWReady),
        .advance(advance),
        .laneIn(laneIn),
        .tag(tag)
    );

    // One lane per burst slice
    for (genvar g = 0; g < LaneCount; g++) begin : genLane
        keystreamLane #(
            .LaneStages(LaneStages),
            .Key(Key)
        ) lane (
            .Clock(Clock),
            .rstN(rstN),
            .advance(advance),
            .laneIn(laneIn[g]),
            .laneOut(laneOut[g])
        );
    end

    burstEgress #(
        .LaneStages(LaneStages)
    ) egress (
        .Clock(Clock),
        .rstN(rstN),
        .tag(tag),
        .laneOut(laneOut),
        .advance(advance),
        .memOut(memOut),
        .memOutMask(memOutMask),
        .memOutValid(memOutValid),
        .memOutReady(memOutReady),
        .backendRData(backendRData),
        .backendRValid(backendRValid),
        .backendRReady(backendRReady)
    );

endmodule

// File: source/pathCipherPkg.sv
// Widths shared by the path cipher blocks
// Path direction enum and the lane and sideband structs

package pathCipherPkg;

    // ------------------------------
    // Burst geometry
    // ------------------------------

    // Keystream lanes per burst
    localparam int LaneCount = 4;

    // Bits per lane slice
    localparam int LaneWidth = 128;

    localparam int BurstWidth = LaneCount * LaneWidth;

    // One mask bit per data byte
    localparam int MaskWidth = BurstWidth / 8;

    // IV field in the low bits of a bucket header
    localparam int IvWidth = 64;

    // ------------------------------
    // Types
    // ------------------------------

    typedef enum logic {
        PathRead  = 1'b0,
        PathWrite = 1'b1
    } pathDirT;

    // Counter block and data slice into one lane
    typedef struct packed {
        logic                 valid;
        logic [LaneWidth-1:0] counter;
        logic [LaneWidth-1:0] data;
    } laneInT;

    typedef struct packed {
        logic                 valid;
        logic [LaneWidth-1:0] data;
    } laneOutT;

    // Burst sideband, travels beside the lanes
    typedef struct packed {
        logic                 valid;
        logic                 header;
        logic [IvWidth-1:0]   iv;
        logic [MaskWidth-1:0] mask;
        pathDirT              dir;
    } burstTagT;

endpackage

// File: tb/pathCipherTb.sv
// Random-stimulus testbench for the path cipher
// Reference model with per-direction queues, value checker and watchdog

`timescale 1ns/100ps

module pathCipherTb import pathCipherPkg::*; ();

    localparam int                   LaneStages   = 4;
    localparam int                   BucketBursts = 4;
    localparam int                   PathBursts   = 12;
    localparam logic [LaneWidth-1:0] Key          = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0;

    localparam int PathCount   = 6;
    localparam int TotalBursts = PathCount * PathBursts;
    localparam int TimeoutNs   = TotalBursts * 40 * 4;

    logic                  Clock;
    logic                  rstN;
    logic [BurstWidth-1:0] memIn;
    logic                  memInValid;
    logic                  memInReady;
    logic [BurstWidth-1:0] memOut;
    logic [MaskWidth-1:0]  memOutMask;
    logic                  memOutValid;
    logic                  memOutReady;
    logic [BurstWidth-1:0] backendWData;
    logic [MaskWidth-1:0]  backendWMask;
    logic                  backendWValid;
    logic                  backendWReady;
    logic [BurstWidth-1:0] backendRData;
    logic                  backendRValid;
    logic                  backendRReady;

    integer seed;
    int     errorCount;
    int     sent;
    int     received;

    // Model state
    pathDirT               modelDir;
    int                    bucketPos;
    int                    pathPos;
    logic [IvWidth-1:0]    modelIv;
    logic [BurstWidth-1:0] readQ [$];
    logic [BurstWidth-1:0] writeQ [$];
    logic [MaskWidth-1:0]  maskQ [$];

    // Handshake and hold tracking between cycles
    logic                  memTaken;
    logic                  writeTaken;
    logic                  memHeld;
    logic [BurstWidth-1:0] memHeldData;
    logic [MaskWidth-1:0]  memHeldMask;
    logic                  readHeld;
    logic [BurstWidth-1:0] readHeldData;

    pathCipher #(
        .LaneStages(LaneStages),
        .BucketBursts(BucketBursts),
        .PathBursts(PathBursts),
        .Key(Key)
    ) uut (
        .Clock(Clock),
        .rstN(rstN),
        .memIn(memIn),
        .memInValid(memInValid),
        .memInReady(memInReady),
        .memOut(memOut),
        .memOutMask(memOutMask),
        .memOutValid(memOutValid),
        .memOutReady(memOutReady),
        .backendWData(backendWData),
        .backendWMask(backendWMask),
        .backendWValid(backendWValid),
        .backendWReady(backendWReady),
        .backendRData(backendRData),
        .backendRValid(backendRValid),
        .backendRReady(backendRReady)
    );

    always #2 Clock = ~Clock;

    // ------------------------------
    // Checking helpers
    // ------------------------------

    task automatic checkValue(input string name, input logic [BurstWidth-1:0] expected,
                              input logic [BurstWidth-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string text);
        $display("Error at %0t: %s", $time, text);
        errorCount++;
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Add-rotate-xor rounds, one per lane stage
    function automatic logic [LaneWidth-1:0] keystream(input logic [LaneWidth-1:0] counter);
        logic [LaneWidth-1:0] state;
        logic [LaneWidth-1:0] keyed;
        state = counter;
        for (int r = 1; r <= LaneStages; r++) begin
            keyed = state ^ Key;
            state = ((keyed << 13) | (keyed >> (LaneWidth - 13))) + LaneWidth'(r);
        end
        return state;
    endfunction

    task automatic acceptBurst(input logic [BurstWidth-1:0] data,
                               input logic [MaskWidth-1:0] mask);
        logic [BurstWidth-1:0] result;
        logic [LaneWidth-1:0]  counter;
        if (bucketPos == 0) begin
            modelIv = data[IvWidth-1:0];
        end
        for (int j = 0; j < LaneCount; j++) begin
            counter = {{(LaneWidth - IvWidth){1'b0}}, modelIv}
                    + LaneWidth'(bucketPos * LaneCount + j);
            result[j*LaneWidth +: LaneWidth] = data[j*LaneWidth +: LaneWidth] ^ keystream(counter);
        end
        // Header IV leaves in clear
        if (bucketPos == 0) begin
            result[IvWidth-1:0] = modelIv;
        end
        if (modelDir == PathRead) begin
            readQ.push_back(result);
        end else begin
            writeQ.push_back(result);
            maskQ.push_back(mask);
        end
        sent++;
        bucketPos = (bucketPos + 1) % BucketBursts;
        pathPos++;
        if (pathPos == PathBursts) begin
            pathPos  = 0;
            modelDir = (modelDir == PathRead) ? PathWrite : PathRead;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    function automatic logic [BurstWidth-1:0] randomBurst();
        logic [BurstWidth-1:0] value;
        for (int i = 0; i < BurstWidth / 32; i++) begin
            value[i*32 +: 32] = $random(seed);
        end
        return value;
    endfunction

    // High three times out of four
    function automatic logic randomHigh();
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic driveInputs();
        if (sent >= TotalBursts) begin
            memInValid    = 1'b0;
            backendWValid = 1'b0;
        end else begin
            // A pending offer stays until it is taken
            if (!memInValid || memTaken) begin
                memInValid = randomHigh();
                memIn      = randomBurst();
            end
            if (!backendWValid || writeTaken) begin
                backendWValid = randomHigh();
                backendWData  = randomBurst();
                backendWMask  = MaskWidth'({$random(seed), $random(seed)});
            end
        end
        memOutReady   = randomHigh();
        backendRReady = randomHigh();
    endtask

    // Runs at the falling edge, inputs and outputs are settled
    task automatic monitorCycle();
        pathDirT expectedDir;
        memTaken   = memInValid && memInReady;
        writeTaken = backendWValid && backendWReady;
        if (modelDir == PathRead) begin
            checkValue("backendWReady", '0, backendWReady);
        end else begin
            checkValue("memInReady", '0, memInReady);
        end
        if (memTaken) begin
            acceptBurst(memIn, '0);
        end
        if (writeTaken) begin
            acceptBurst(backendWData, backendWMask);
        end

        if (memOutValid && backendRValid) begin
            reportProblem("memOutValid and backendRValid are high together");
        end
        if (memHeld) begin
            checkValue("memOutValid", 1, memOutValid);
            checkValue("memOut", memHeldData, memOut);
            checkValue("memOutMask", memHeldMask, memOutMask);
        end
        if (readHeld) begin
            checkValue("backendRValid", 1, backendRValid);
            checkValue("backendRData", readHeldData, backendRData);
        end

        // Paths alternate, starting with the backend
        expectedDir = ((received / PathBursts) % 2 == 0) ? PathRead : PathWrite;
        if (backendRValid && backendRReady) begin
            checkValue("outputDir", expectedDir, PathRead);
            if (readQ.size() == 0) begin
                reportProblem("backendRData delivered a burst the model did not expect");
            end else begin
                checkValue("backendRData", readQ.pop_front(), backendRData);
            end
            received++;
        end
        if (memOutValid && memOutReady) begin
            checkValue("outputDir", expectedDir, PathWrite);
            if (writeQ.size() == 0) begin
                reportProblem("memOut delivered a burst the model did not expect");
            end else begin
                checkValue("memOut", writeQ.pop_front(), memOut);
                checkValue("memOutMask", maskQ.pop_front(), memOutMask);
            end
            received++;
        end

        memHeld      = memOutValid && !memOutReady;
        memHeldData  = memOut;
        memHeldMask  = memOutMask;
        readHeld     = backendRValid && !backendRReady;
        readHeldData = backendRData;
    endtask

    task automatic runCycle();
        @(posedge Clock);
        #0.5;
        driveInputs();
        @(negedge Clock);
        monitorCycle();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        Clock         = 1'b0;
        rstN          = 1'b0;
        memIn         = '0;
        memInValid    = 1'b0;
        memOutReady   = 1'b0;
        backendWData  = '0;
        backendWMask  = '0;
        backendWValid = 1'b0;
        backendRReady = 1'b0;
        seed          = 46020;
        errorCount    = 0;
        sent          = 0;
        received      = 0;
        modelDir      = PathRead;
        bucketPos     = 0;
        pathPos       = 0;
        modelIv       = '0;
        memTaken      = 1'b0;
        writeTaken    = 1'b0;
        memHeld       = 1'b0;
        readHeld      = 1'b0;

        repeat (16) @(posedge Clock);
        #0.5;
        rstN = 1'b1;
        driveInputs();

        // First cycle out of reset
        @(negedge Clock);
        checkValue("memOutValid", '0, memOutValid);
        checkValue("backendRValid", '0, backendRValid);
        checkValue("memInReady", '0, memInReady);
        checkValue("backendWReady", '0, backendWReady);
        monitorCycle();

        while (received < TotalBursts) begin
            runCycle();
        end
        // Extra cycles catch duplicated outputs
        repeat (LaneStages + 4) begin
            runCycle();
        end
        if (readQ.size() != 0 || writeQ.size() != 0) begin
            reportProblem("bursts were still expected when the run ended");
        end

        $display("Bursts in %0d, bursts out %0d, errors %0d", sent, received, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TimeoutNs);
        reportProblem("timeout, not all bursts came out of the cipher");
        $display("Bursts in %0d, bursts out %0d, errors %0d", sent, received, errorCount);
        $display("TB FAILED");
        $finish;
    end

endmodule
